// File: Makefile
# Verilator build and run for the SHA-256 padder testbench

VERILATOR ?= verilator
TOP ?= sha_pad_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/byte_write_pipe.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module byte_write_pipe (
	input logic clock,
	input logic regin_reset,
	input sha_pad_pkg::pad_wr_t wr_req,
	input sha_pad_pkg::byte_t mem_data,
	input sha_pad_pkg::byte_idx_t msg_len_q,
	output sha_pad_pkg::pad_wr_t wr_out,
	output sha_pad_pkg::byte_t wr_data
);

	localparam int LEN_BITS = 2 * `PAD_BYTE_BITS;

	sha_pad_pkg::pad_wr_t stage [`PAD_MEM_LATENCY];	// stage[0] is the youngest
	logic [LEN_BITS-1:0] bit_len;	// Message length in bits

	always_ff @(posedge clock) begin
		if (regin_reset) begin
			for (int i = 0; i < `PAD_MEM_LATENCY; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= wr_req;
			for (int i = 1; i < `PAD_MEM_LATENCY; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign wr_out = stage[`PAD_MEM_LATENCY-1];

	// Length times eight
	assign bit_len = {{(LEN_BITS - `PAD_ADDR_BITS - 3){1'b0}}, msg_len_q, 3'b000};

	always_comb begin
		case (wr_out.src)
			sha_pad_pkg::src_mem: wr_data = mem_data;	// Arrives now for this request
			sha_pad_pkg::src_marker: wr_data = `PAD_MARKER;
			sha_pad_pkg::src_len_hi: wr_data = bit_len[LEN_BITS-1:`PAD_BYTE_BITS];
			sha_pad_pkg::src_len_lo: wr_data = bit_len[`PAD_BYTE_BITS-1:0];
			default: wr_data = '0;
		endcase
	end

endmodule

// File: design/pad_block_reg.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module pad_block_reg (
	input logic clock,
	input logic regin_reset,
	input logic clear_block,
	input sha_pad_pkg::pad_wr_t wr_out,
	input sha_pad_pkg::byte_t wr_data,
	output sha_pad_pkg::block_t block
);

	int unsigned lsb;	// Bottom bit of the addressed byte

	// Index 0 maps to the most significant byte
	assign lsb = (`PAD_BYTES - 1 - int'(wr_out.idx)) * `PAD_BYTE_BITS;

	always_ff @(posedge clock) begin
		if (regin_reset || clear_block) begin
			block <= '0;	// Unwritten bytes must read as zero padding
		end else if (wr_out.en) begin
			block[lsb +: `PAD_BYTE_BITS] <= wr_data;
		end
	end

	// Pipe must be empty by the time a new message clears the block
	a_clear_no_write: assert property (@(posedge clock) disable iff (regin_reset)
		!(clear_block && wr_out.en));

endmodule

// File: design/pad_fsm.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module pad_fsm (
	input logic clock,
	input logic regin_reset,
	input logic go,
	input sha_pad_pkg::byte_idx_t msg_len,
	output sha_pad_pkg::mem_req_t mem_req,
	output sha_pad_pkg::pad_wr_t wr_req,
	output logic clear_block,
	output sha_pad_pkg::byte_idx_t msg_len_q,
	output logic pad_rdy
);

	localparam int WAIT_BITS = $clog2(`PAD_MEM_LATENCY + 1);

	sha_pad_pkg::pad_state_e state;
	sha_pad_pkg::pad_state_e state_nx;
	sha_pad_pkg::byte_idx_t addr_cnt;	// SRAM address, also the write index in fetch
	logic [WAIT_BITS-1:0] wait_cnt;	// Cycles spent in len_lo
	logic last_addr;
	logic drained;

	assign last_addr = (addr_cnt == msg_len_q - 1'b1);
	assign drained = (wait_cnt == WAIT_BITS'(`PAD_MEM_LATENCY));

	always_comb begin
		state_nx = state;
		case (state)
			sha_pad_pkg::idle, sha_pad_pkg::done: begin
				if (go) begin
					state_nx = sha_pad_pkg::load;
				end
			end
			sha_pad_pkg::load: begin
				// msg_len_q is not loaded yet, look at the input
				if (msg_len == '0) begin
					state_nx = sha_pad_pkg::marker;
				end else begin
					state_nx = sha_pad_pkg::fetch;
				end
			end
			sha_pad_pkg::fetch: begin
				if (last_addr) begin
					state_nx = sha_pad_pkg::marker;
				end
			end
			sha_pad_pkg::marker: state_nx = sha_pad_pkg::len_hi;
			sha_pad_pkg::len_hi: state_nx = sha_pad_pkg::len_lo;
			sha_pad_pkg::len_lo: begin
				if (drained) begin	// Last write has reached the block
					state_nx = sha_pad_pkg::done;
				end
			end
			default: state_nx = sha_pad_pkg::idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (regin_reset) begin
			state <= sha_pad_pkg::idle;
			addr_cnt <= '0;
			wait_cnt <= '0;
			msg_len_q <= '0;
		end else begin
			state <= state_nx;
			if (state == sha_pad_pkg::load) begin
				msg_len_q <= msg_len;
			end
			if (state == sha_pad_pkg::fetch) begin
				addr_cnt <= addr_cnt + 1'b1;
			end else begin
				addr_cnt <= '0;
			end
			if (state == sha_pad_pkg::len_lo) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
			end
		end
	end

	assign mem_req.en = (state == sha_pad_pkg::fetch);
	assign mem_req.addr = addr_cnt;

	always_comb begin
		wr_req.en = 1'b0;
		wr_req.src = sha_pad_pkg::src_mem;
		wr_req.idx = addr_cnt;
		case (state)
			sha_pad_pkg::fetch: begin
				wr_req.en = 1'b1;	// Same index as the SRAM read
			end
			sha_pad_pkg::marker: begin
				wr_req.en = 1'b1;
				wr_req.src = sha_pad_pkg::src_marker;
				wr_req.idx = msg_len_q;	// Right after the last message byte
			end
			sha_pad_pkg::len_hi: begin
				wr_req.en = 1'b1;
				wr_req.src = sha_pad_pkg::src_len_hi;
				wr_req.idx = sha_pad_pkg::byte_idx_t'(`PAD_LEN_HI_IDX);
			end
			sha_pad_pkg::len_lo: begin
				wr_req.en = (wait_cnt == '0);	// Only on the first cycle
				wr_req.src = sha_pad_pkg::src_len_lo;
				wr_req.idx = sha_pad_pkg::byte_idx_t'(`PAD_LEN_LO_IDX);
			end
			default: wr_req.en = 1'b0;
		endcase
	end

	assign clear_block = (state == sha_pad_pkg::load);
	assign pad_rdy = (state == sha_pad_pkg::done);

	// Reads stay inside the message
	a_mem_in_fetch: assert property (@(posedge clock) disable iff (regin_reset)
		mem_req.en |-> (mem_req.addr < msg_len_q));

	// Reads run back to back, one address further each cycle
	a_mem_seq: assert property (@(posedge clock) disable iff (regin_reset)
		mem_req.en && !last_addr |=>
		mem_req.en && (mem_req.addr == $past(mem_req.addr) + 1'b1));

endmodule

// File: design/sha_pad_defs.svh
`ifndef SHA_PAD_DEFS_SVH
`define SHA_PAD_DEFS_SVH

// Block geometry
`define PAD_BLOCK_BITS 512
`define PAD_BYTES 64
`define PAD_ADDR_BITS 6
`define PAD_BYTE_BITS 8

// Message limits and padding constants
`define PAD_MAX_MSG_LEN 55
`define PAD_MARKER 8'h80
`define PAD_LEN_HI_IDX 62
`define PAD_LEN_LO_IDX 63

// SRAM read cycle plus input register
`define PAD_MEM_LATENCY 2

`endif

// File: design/sha_pad_pkg.sv
`include "sha_pad_defs.svh"

package sha_pad_pkg;

	typedef logic [`PAD_BYTE_BITS-1:0] byte_t;	// One message byte
	typedef logic [`PAD_ADDR_BITS-1:0] byte_idx_t;	// Block byte index or SRAM address
	typedef logic [`PAD_BLOCK_BITS-1:0] block_t;	// Byte 0 sits in the top bits

	// Padding sequence
	typedef enum logic [2:0] {
		idle,
		load,	// Latch length, clear block
		fetch,	// One SRAM read per cycle
		marker,
		len_hi,
		len_lo,	// Also covers the pipe drain
		done
	} pad_state_e;

	// Where a written byte comes from
	typedef enum logic [1:0] {
		src_mem,
		src_marker,
		src_len_hi,
		src_len_lo
	} byte_src_e;

	typedef struct packed {
		logic en;
		byte_idx_t addr;
	} mem_req_t;

	typedef struct packed {
		logic en;
		byte_src_e src;
		byte_idx_t idx;
	} pad_wr_t;

endpackage

// File: design/sha_pad_top.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module sha_pad_top (
	input logic clock,
	input logic regin_reset,
	input logic go,
	input sha_pad_pkg::byte_idx_t msg_len,
	input sha_pad_pkg::byte_t msg_mem_data,
	output sha_pad_pkg::mem_req_t mem_req,
	output sha_pad_pkg::block_t pad_block,
	output logic pad_rdy
);

	logic go_r;	// Registered go strobe
	sha_pad_pkg::byte_idx_t msg_len_r;
	sha_pad_pkg::byte_t mem_data_r;	// SRAM data, one cycle behind the SRAM

	sha_pad_pkg::pad_wr_t wr_req;	// From FSM, undelayed
	sha_pad_pkg::pad_wr_t wr_out;	// Lined up with mem_data_r
	sha_pad_pkg::byte_t wr_data;
	sha_pad_pkg::byte_idx_t msg_len_q;	// Length latched for this message
	logic clear_block;

	always_ff @(posedge clock) begin
		if (regin_reset) begin
			go_r <= 1'b0;
		end else begin
			go_r <= go;
		end
	end

	// Payload inputs only need a plain register
	always_ff @(posedge clock) begin
		msg_len_r <= msg_len;
		mem_data_r <= msg_mem_data;
	end

	pad_fsm u_pad_fsm (
		.clock(clock),
		.regin_reset(regin_reset),
		.go(go_r),
		.msg_len(msg_len_r),
		.mem_req(mem_req),
		.wr_req(wr_req),
		.clear_block(clear_block),
		.msg_len_q(msg_len_q),
		.pad_rdy(pad_rdy)
	);

	byte_write_pipe u_byte_write_pipe (
		.clock(clock),
		.regin_reset(regin_reset),
		.wr_req(wr_req),
		.mem_data(mem_data_r),
		.msg_len_q(msg_len_q),
		.wr_out(wr_out),
		.wr_data(wr_data)
	);

	pad_block_reg u_pad_block_reg (
		.clock(clock),
		.regin_reset(regin_reset),
		.clear_block(clear_block),
		.wr_out(wr_out),
		.wr_data(wr_data),
		.block(pad_block)
	);

	// The length latched on load must fit one block
	a_go_len: assert property (@(posedge clock) disable iff (regin_reset)
		clear_block |-> (msg_len_r <= `PAD_MAX_MSG_LEN));

endmodule

// File: flist.f
+incdir+design
design/sha_pad_pkg.sv
design/pad_fsm.sv
design/byte_write_pipe.sv
design/pad_block_reg.sv
design/sha_pad_top.sv
verification/msg_sram_model.sv
verification/sha_pad_tb.sv

// File: verification/msg_sram_model.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module msg_sram_model (
	input logic clock,
	input sha_pad_pkg::mem_req_t mem_req,
	input logic wr_en,	// Load port for the testbench
	input sha_pad_pkg::byte_idx_t wr_addr,
	input sha_pad_pkg::byte_t wr_data,
	output sha_pad_pkg::byte_t rd_data
);

	sha_pad_pkg::byte_t mem [`PAD_BYTES];	// One message byte per address

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read data appears after the sampling edge and holds until the next read
	always_ff @(posedge clock) begin
		if (mem_req.en) begin
			rd_data <= mem[mem_req.addr];
		end
	end

endmodule

// File: verification/sha_pad_tb.sv
`timescale 1ns/1ns
`include "sha_pad_defs.svh"

module sha_pad_tb;

	localparam int RDY_TIMEOUT = 200;	// Cycles allowed for one message
	localparam int DROP_TIMEOUT = 10;	// Cycles for ready to fall after go

	logic clock;
	logic regin_reset;
	logic go;
	sha_pad_pkg::byte_idx_t msg_len;
	sha_pad_pkg::byte_t msg_mem_data;
	sha_pad_pkg::mem_req_t mem_req;
	sha_pad_pkg::block_t pad_block;
	logic pad_rdy;

	logic sram_wr_en;
	sha_pad_pkg::byte_idx_t sram_wr_addr;
	sha_pad_pkg::byte_t sram_wr_data;

	integer seed;
	sha_pad_pkg::byte_t msg [`PAD_BYTES];	// Current message, mirrored in the SRAM
	sha_pad_pkg::block_t last_block;	// Expected block of the previous message
	logic rdy_exp;	// Ready level expected between messages
	sha_pad_pkg::mem_req_t exp_req;
	int req_count;	// Enabled memory requests seen for this message

	sha_pad_top u_sha_pad_top (
		.clock(clock),
		.regin_reset(regin_reset),
		.go(go),
		.msg_len(msg_len),
		.msg_mem_data(msg_mem_data),
		.mem_req(mem_req),
		.pad_block(pad_block),
		.pad_rdy(pad_rdy)
	);

	msg_sram_model u_msg_sram_model (
		.clock(clock),
		.mem_req(mem_req),
		.wr_en(sram_wr_en),
		.wr_addr(sram_wr_addr),
		.wr_data(sram_wr_data),
		.rd_data(msg_mem_data)
	);

	always #4 clock = ~clock;

	// Message bytes from the top, marker, zeros, bit length at the end
	function automatic sha_pad_pkg::block_t ref_pad_block(input int len);
		sha_pad_pkg::block_t blk;
		logic [15:0] bit_len;
		blk = '0;
		for (int i = 0; i < len; i++) begin
			blk[(63 - i) * 8 +: 8] = msg[i];
		end
		blk[(63 - len) * 8 +: 8] = 8'h80;
		bit_len = 16'(len * 8);
		blk[15:0] = bit_len;
		return blk;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_block(input string name, input sha_pad_pkg::block_t got,
		input sha_pad_pkg::block_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("MISMATCH at %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_rdy(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("MISMATCH at %0t ns: %s = %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_mem_req(input string name, input sha_pad_pkg::mem_req_t got,
		input sha_pad_pkg::mem_req_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf(
				"MISMATCH at %0t ns: %s = en %b addr %0d, expected en %b addr %0d",
				$time, name, got.en, got.addr, exp.en, exp.addr));
		end
	endtask

	// Every enabled read must hit the next address in order
	always @(negedge clock) begin
		if (!regin_reset && mem_req.en) begin
			exp_req.en = 1'b1;
			exp_req.addr = sha_pad_pkg::byte_idx_t'(req_count);
			check_mem_req("mem_req", mem_req, exp_req);
			req_count = req_count + 1;
		end
	end

	task automatic wait_rdy_low(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (pad_rdy && n < limit);
		if (pad_rdy) begin
			stop_on_error("pad_rdy stayed high after a go was given");
		end
	endtask

	task automatic wait_rdy_high(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!pad_rdy && n < limit);
		if (!pad_rdy) begin
			stop_on_error($sformatf("pad_rdy never came high within %0d cycles", limit));
		end
	endtask

	// New random bytes at every address, so stale data would show up
	task automatic load_message();
		for (int i = 0; i < `PAD_BYTES; i++) begin
			msg[i] = sha_pad_pkg::byte_t'($random(seed));
			@(posedge clock);
			sram_wr_en <= 1'b1;
			sram_wr_addr <= sha_pad_pkg::byte_idx_t'(i);
			sram_wr_data <= msg[i];
		end
		@(posedge clock);
		sram_wr_en <= 1'b0;
		@(negedge clock);
		check_rdy("pad_rdy", pad_rdy, rdy_exp);	// Level holds until the next go
		check_block("pad_block", pad_block, last_block);	// Block holds until the next go
	endtask

	task automatic run_message(input int len);
		sha_pad_pkg::block_t exp_block;
		load_message();
		@(posedge clock);
		go <= 1'b1;
		msg_len <= sha_pad_pkg::byte_idx_t'(len);
		req_count = 0;
		@(posedge clock);
		go <= 1'b0;
		wait_rdy_low(DROP_TIMEOUT);
		wait_rdy_high(RDY_TIMEOUT);
		exp_block = ref_pad_block(len);
		check_block("pad_block", pad_block, exp_block);
		if (req_count != len) begin
			stop_on_error($sformatf("%0d memory reads were issued for a %0d byte message",
				req_count, len));
		end
		last_block = exp_block;
		rdy_exp = 1'b1;
	endtask

	initial begin
		int len;
		clock = 1'b0;
		regin_reset = 1'b1;
		go = 1'b0;
		msg_len = '0;
		sram_wr_en = 1'b0;
		sram_wr_addr = '0;
		sram_wr_data = '0;
		seed = 32'ha25c;
		req_count = 0;
		last_block = '0;
		rdy_exp = 1'b0;
		exp_req = '0;
		repeat (16) @(posedge clock);
		regin_reset <= 1'b0;
		@(negedge clock);
		check_rdy("pad_rdy", pad_rdy, 1'b0);
		check_mem_req("mem_req", mem_req, '0);
		check_block("pad_block", pad_block, '0);

		run_message(0);	// Marker only, no reads
		run_message(`PAD_MAX_MSG_LEN);
		repeat (20) begin
			len = 1 + int'($unsigned($random(seed)) % `PAD_MAX_MSG_LEN);
			run_message(len);
		end
		run_message(`PAD_MAX_MSG_LEN);	// Long block, then a short one over it
		run_message(3);

		$display("test passed");
		$finish;
	end

endmodule
